// ==== hw/csr_cmd_port.sv ====
module csr_cmd_port (
    input  logic               clk,
    input  logic               rst,

    // core side, four-phase
    input  logic               req_i,
    input  trap_pkg::csr_cmd_t cmd_i,
    output logic               ack_o,
    output trap_pkg::csr_rsp_t rsp_o,

    // controller side
    output logic               issue_o,
    output trap_pkg::csr_cmd_t cmd_o,
    input  trap_pkg::csr_rsp_t rsp_i
);

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        ACK,
        WAIT_LOW
    } state_t;

    state_t             state_q;
    state_t             state_d;
    trap_pkg::csr_cmd_t cmd_q;
    trap_pkg::csr_rsp_t rsp_q;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:     if (req_i) state_d = EXEC;
            EXEC:     state_d = ACK;               // single execute cycle
            ACK:      state_d = req_i ? WAIT_LOW : IDLE;
            WAIT_LOW: if (!req_i) state_d = IDLE;  // core still holding req
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // command latch, payload only
    always_ff @(posedge clk) begin
        if (state_q == IDLE && req_i) begin
            cmd_q <= cmd_i;
        end
    end

    // response register, held until the next command executes
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_q <= '0;
        end else if (state_q == EXEC) begin
            rsp_q <= rsp_i;
        end
    end

    assign issue_o = (state_q == EXEC);
    assign cmd_o   = cmd_q;
    assign ack_o   = (state_q == ACK) || (state_q == WAIT_LOW);
    assign rsp_o   = rsp_q;

endmodule

// ==== hw/mcsr_file.sv ====
module mcsr_file (
    input  logic               clk,
    input  logic               rst,

    input  trap_pkg::csr_wr_t  wr_i,
    input  trap_pkg::csr_idx_t idx_i,     // read index
    input  trap_pkg::xlen_t    mtime_i,
    input  logic               mtip_i,

    output trap_pkg::xlen_t    rdata_o,
    output trap_pkg::xlen_t    mstatus_o,
    output trap_pkg::xlen_t    mtvec_o,
    output trap_pkg::xlen_t    mepc_o,
    output trap_pkg::xlen_t    mtimecmp_o,
    output logic               irq_o
);

    trap_pkg::xlen_t mstatus_q;
    trap_pkg::xlen_t mie_q;
    trap_pkg::xlen_t mtvec_q;
    trap_pkg::xlen_t mepc_q;
    trap_pkg::xlen_t mcause_q;
    trap_pkg::xlen_t mtimecmp_q;
    trap_pkg::xlen_t mip_val;

    logic wr_mstatus;
    logic wr_mie;
    logic wr_mtvec;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mtimecmp;

    // write decode; mip and mtime have no entry, so writes to them drop
    assign wr_mstatus  = wr_i.we && (wr_i.idx == trap_pkg::CSR_MSTATUS);
    assign wr_mie      = wr_i.we && (wr_i.idx == trap_pkg::CSR_MIE);
    assign wr_mtvec    = wr_i.we && (wr_i.idx == trap_pkg::CSR_MTVEC);
    assign wr_mepc     = wr_i.we && (wr_i.idx == trap_pkg::CSR_MEPC);
    assign wr_mcause   = wr_i.we && (wr_i.idx == trap_pkg::CSR_MCAUSE);
    assign wr_mtimecmp = wr_i.we && (wr_i.idx == trap_pkg::CSR_MTIMECMP);

    // mstatus: only MIE and MPIE are implemented
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_q <= '0;
        end else if (wr_i.trap_enter) begin
            mstatus_q[trap_pkg::MSTATUS_MPIE] <= mstatus_q[trap_pkg::MSTATUS_MIE];
            mstatus_q[trap_pkg::MSTATUS_MIE]  <= 1'b0;
        end else if (wr_i.trap_return) begin
            mstatus_q[trap_pkg::MSTATUS_MIE]  <= mstatus_q[trap_pkg::MSTATUS_MPIE];
            mstatus_q[trap_pkg::MSTATUS_MPIE] <= 1'b1;
        end else if (wr_mstatus) begin
            mstatus_q                         <= '0;
            mstatus_q[trap_pkg::MSTATUS_MIE]  <= wr_i.data[trap_pkg::MSTATUS_MIE];
            mstatus_q[trap_pkg::MSTATUS_MPIE] <= wr_i.data[trap_pkg::MSTATUS_MPIE];
        end
    end

    // mie: timer enable only
    always_ff @(posedge clk) begin
        if (rst) begin
            mie_q <= '0;
        end else if (wr_mie) begin
            mie_q                     <= '0;
            mie_q[trap_pkg::MIE_MTIE] <= wr_i.data[trap_pkg::MIE_MTIE];
        end
    end

    // mtvec, direct mode only
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec_q <= '0;
        end else if (wr_mtvec) begin
            mtvec_q <= {wr_i.data[63:2], 2'b00};
        end
    end

    // mepc and mcause also load on trap entry
    always_ff @(posedge clk) begin
        if (rst) begin
            mepc_q   <= '0;
            mcause_q <= '0;
        end else if (wr_i.trap_enter) begin
            mepc_q   <= wr_i.save_pc;
            mcause_q <= wr_i.cause;
        end else begin
            if (wr_mepc) mepc_q <= wr_i.data;
            if (wr_mcause) mcause_q <= wr_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp_q <= '1;   // nothing pending out of reset
        end else if (wr_mtimecmp) begin
            mtimecmp_q <= wr_i.data;
        end
    end

    // mip mirrors the timer pending bit
    always_comb begin
        mip_val                     = '0;
        mip_val[trap_pkg::MIP_MTIP] = mtip_i;
    end

    // read mux
    always_comb begin
        case (idx_i)
            trap_pkg::CSR_MSTATUS:  rdata_o = mstatus_q;
            trap_pkg::CSR_MIE:      rdata_o = mie_q;
            trap_pkg::CSR_MTVEC:    rdata_o = mtvec_q;
            trap_pkg::CSR_MEPC:     rdata_o = mepc_q;
            trap_pkg::CSR_MCAUSE:   rdata_o = mcause_q;
            trap_pkg::CSR_MIP:      rdata_o = mip_val;
            trap_pkg::CSR_MTIME:    rdata_o = mtime_i;
            trap_pkg::CSR_MTIMECMP: rdata_o = mtimecmp_q;
            default:                rdata_o = '0;
        endcase
    end

    assign mstatus_o  = mstatus_q;
    assign mtvec_o    = mtvec_q;
    assign mepc_o     = mepc_q;
    assign mtimecmp_o = mtimecmp_q;

    // level interrupt to the core
    assign irq_o = mstatus_q[trap_pkg::MSTATUS_MIE] & mie_q[trap_pkg::MIE_MTIE] & mtip_i;

endmodule

// ==== hw/mtimer.sv ====
module mtimer #(
    parameter int TICK_DIV = 1
) (
    input  logic            clk,
    input  logic            rst,
    input  trap_pkg::xlen_t mtimecmp_i,
    output trap_pkg::xlen_t mtime_o,
    output logic            mtip_o
);

    localparam int CW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CW-1:0]   pre_cnt;
    logic            tick;
    trap_pkg::xlen_t mtime_q;

    assign tick = (pre_cnt == CW'(TICK_DIV - 1));

    // prescaler
    always_ff @(posedge clk) begin
        if (rst || tick) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime_q <= '0;
            mtip_o  <= 1'b0;
        end else begin
            if (tick) mtime_q <= mtime_q + 64'd1;
            mtip_o <= (mtime_q >= mtimecmp_i);   // one cycle behind the compare
        end
    end

    assign mtime_o = mtime_q;

endmodule

// ==== hw/trap_ctrl.sv ====
module trap_ctrl (
    input  logic               issue_i,
    input  trap_pkg::csr_cmd_t cmd_i,
    input  trap_pkg::xlen_t    rdata_i,    // old value of cmd_i.idx
    input  trap_pkg::xlen_t    mstatus_i,
    input  trap_pkg::xlen_t    mtvec_i,
    input  trap_pkg::xlen_t    mepc_i,

    output trap_pkg::csr_wr_t  wr_o,
    output trap_pkg::csr_rsp_t rsp_o
);

    trap_pkg::xlen_t new_val;
    logic            do_write;
    logic            do_enter;
    logic            do_return;
    logic            irq_ok;
    trap_pkg::xlen_t cause;

    // interrupt entry only when globally enabled
    assign irq_ok = mstatus_i[trap_pkg::MSTATUS_MIE];

    // read-modify-write value and entry decode
    always_comb begin
        new_val   = rdata_i;
        do_write  = 1'b0;
        do_enter  = 1'b0;
        do_return = 1'b0;
        cause     = trap_pkg::CAUSE_ECALL_M;
        case (cmd_i.op)
            trap_pkg::OP_READ: begin
                do_write = 1'b0;
            end
            trap_pkg::OP_RW: begin
                new_val  = cmd_i.wdata;
                do_write = 1'b1;
            end
            trap_pkg::OP_RS: begin
                new_val  = rdata_i | cmd_i.wdata;
                do_write = (cmd_i.wdata != '0);   // rs with zero is a pure read
            end
            trap_pkg::OP_RC: begin
                new_val  = rdata_i & ~cmd_i.wdata;
                do_write = (cmd_i.wdata != '0);
            end
            trap_pkg::OP_ECALL: begin
                do_enter = 1'b1;
            end
            trap_pkg::OP_MRET: begin
                do_return = 1'b1;
            end
            trap_pkg::OP_IRQ: begin
                do_enter = irq_ok;
                cause    = trap_pkg::CAUSE_MTIMER;
            end
            default: begin
                do_write = 1'b0;
            end
        endcase
    end

    // write request, only in the issue cycle
    always_comb begin
        wr_o             = '0;
        wr_o.idx         = cmd_i.idx;
        wr_o.data        = new_val;
        wr_o.save_pc     = cmd_i.pc;
        wr_o.cause       = cause;
        wr_o.we          = issue_i & do_write;
        wr_o.trap_enter  = issue_i & do_enter;
        wr_o.trap_return = issue_i & do_return;
    end

    // response, registered by the port
    always_comb begin
        rsp_o          = '0;
        rsp_o.redirect = do_enter | do_return;
        if (do_enter) begin
            rsp_o.target = mtvec_i;
        end else if (do_return) begin
            rsp_o.target = mepc_i;   // mepc before any update
        end
        case (cmd_i.op)
            trap_pkg::OP_READ,
            trap_pkg::OP_RW,
            trap_pkg::OP_RS,
            trap_pkg::OP_RC: rsp_o.rdata = rdata_i;
            default:         rsp_o.rdata = '0;
        endcase
    end

endmodule

// ==== hw/trap_pkg.sv ====
package trap_pkg;

    // data widths
    typedef logic [63:0] xlen_t;
    typedef logic [2:0]  csr_idx_t;     // compact csr index, not the 12-bit number

    // csr index map
    localparam csr_idx_t CSR_MSTATUS  = 3'd0;
    localparam csr_idx_t CSR_MIE      = 3'd1;
    localparam csr_idx_t CSR_MTVEC    = 3'd2;
    localparam csr_idx_t CSR_MEPC     = 3'd3;
    localparam csr_idx_t CSR_MCAUSE   = 3'd4;
    localparam csr_idx_t CSR_MIP      = 3'd5;  // read only
    localparam csr_idx_t CSR_MTIME    = 3'd6;  // read only
    localparam csr_idx_t CSR_MTIMECMP = 3'd7;

    // command opcodes from the core
    typedef enum logic [2:0] {
        OP_READ  = 3'd0,
        OP_RW    = 3'd1,
        OP_RS    = 3'd2,
        OP_RC    = 3'd3,
        OP_ECALL = 3'd4,
        OP_MRET  = 3'd5,
        OP_IRQ   = 3'd6    // take pending timer interrupt
    } csr_op_t;

    // field positions
    localparam int unsigned MSTATUS_MIE  = 3;
    localparam int unsigned MSTATUS_MPIE = 7;
    localparam int unsigned MIE_MTIE     = 7;
    localparam int unsigned MIP_MTIP     = 7;

    // mcause codes
    localparam xlen_t CAUSE_ECALL_M = 64'd11;
    localparam xlen_t CAUSE_MTIMER  = {1'b1, 63'd7};  // interrupt bit + code 7

    // command as presented by the core
    typedef struct packed {
        csr_op_t  op;
        csr_idx_t idx;
        xlen_t    wdata;
        xlen_t    pc;
    } csr_cmd_t;

    // response back to the core
    typedef struct packed {
        xlen_t rdata;      // old csr value
        logic  redirect;   // control flow change
        xlen_t target;
    } csr_rsp_t;

    // write request from trap_ctrl into mcsr_file
    typedef struct packed {
        logic     we;
        csr_idx_t idx;
        xlen_t    data;
        logic     trap_enter;
        logic     trap_return;
        xlen_t    save_pc;  // goes to mepc on trap_enter
        xlen_t    cause;    // goes to mcause on trap_enter
    } csr_wr_t;

endpackage

// ==== hw/trap_unit_top.sv ====
module trap_unit_top #(
    parameter int TICK_DIV = 1
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               req_i,
    input  trap_pkg::csr_cmd_t cmd_i,
    output logic               ack_o,
    output trap_pkg::csr_rsp_t rsp_o,

    output logic               irq_o
);

    logic               issue;
    trap_pkg::csr_cmd_t cmd;
    trap_pkg::csr_rsp_t ctrl_rsp;
    trap_pkg::csr_wr_t  wr;
    trap_pkg::xlen_t    rdata;
    trap_pkg::xlen_t    mstatus;
    trap_pkg::xlen_t    mtvec;
    trap_pkg::xlen_t    mepc;
    trap_pkg::xlen_t    mtimecmp;
    trap_pkg::xlen_t    mtime;
    logic               mtip;

    csr_cmd_port u_port (
        .clk     (clk),
        .rst     (rst),
        .req_i   (req_i),
        .cmd_i   (cmd_i),
        .ack_o   (ack_o),
        .rsp_o   (rsp_o),
        .issue_o (issue),
        .cmd_o   (cmd),
        .rsp_i   (ctrl_rsp)
    );

    trap_ctrl u_ctrl (
        .issue_i   (issue),
        .cmd_i     (cmd),
        .rdata_i   (rdata),
        .mstatus_i (mstatus),
        .mtvec_i   (mtvec),
        .mepc_i    (mepc),
        .wr_o      (wr),
        .rsp_o     (ctrl_rsp)
    );

    mcsr_file u_csr (
        .clk        (clk),
        .rst        (rst),
        .wr_i       (wr),
        .idx_i      (cmd.idx),    // latched command selects the read
        .mtime_i    (mtime),
        .mtip_i     (mtip),
        .rdata_o    (rdata),
        .mstatus_o  (mstatus),
        .mtvec_o    (mtvec),
        .mepc_o     (mepc),
        .mtimecmp_o (mtimecmp),
        .irq_o      (irq_o)
    );

    mtimer #(
        .TICK_DIV (TICK_DIV)
    ) u_timer (
        .clk        (clk),
        .rst        (rst),
        .mtimecmp_i (mtimecmp),
        .mtime_o    (mtime),
        .mtip_o     (mtip)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run with Verilator; the result comes from the simulation output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module trap_unit_tb -f vlog.f -o trap_unit_sim &&
./obj_dir/trap_unit_sim | tee /dev/stderr | grep -qx "Test passed" ||
{ echo "simulation did not pass"; exit 1; }

// ==== sim/trap_unit_assertions.sv ====
module trap_unit_assertions (
    input logic               clk,
    input logic               rst,
    input logic               req_i,
    input logic               ack_o,
    input trap_pkg::csr_rsp_t rsp_o,
    input logic               irq_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // four-phase sequencing of ack_o against req_i
    ack_rise_with_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack_o) |-> $past(req_i))
        else $error("ack_o rose while req_i was low");

    ack_held_with_req: assert property (@(posedge clk) disable iff (rst)
        (ack_o && req_i) |=> ack_o)
        else $error("ack_o dropped while req_i was still high");

    ack_falls_after_req: assert property (@(posedge clk) disable iff (rst)
        (ack_o && !req_i) |=> !ack_o)
        else $error("ack_o stayed high after req_i was sampled low");

    rsp_stable_during_ack: assert property (@(posedge clk) disable iff (rst)
        (ack_o && $past(ack_o)) |-> $stable(rsp_o))
        else $error("rsp_o changed while ack_o was high");

    irq_low_after_reset: assert property (@(posedge clk)
        rst |=> !irq_o)
        else $error("irq_o high in the cycle after reset");

endmodule

bind trap_unit_top trap_unit_assertions u_assertions (
    .clk   (clk),
    .rst   (rst),
    .req_i (req_i),
    .ack_o (ack_o),
    .rsp_o (rsp_o),
    .irq_o (irq_o)
);

// ==== sim/trap_unit_tb.sv ====
module trap_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int              WAIT_LIMIT = 200;   // cycles per wait loop
    localparam trap_pkg::xlen_t VEC        = 64'h0000_0000_8000_1000;
    localparam trap_pkg::xlen_t ECALL_PC   = 64'h0000_0000_2000_0444;
    localparam trap_pkg::xlen_t IRQ_PC     = 64'h0000_0000_3000_0100;

    logic               clk;
    logic               rst;
    logic               req_i;
    trap_pkg::csr_cmd_t cmd_i;
    logic               ack_o;
    trap_pkg::csr_rsp_t rsp_o;
    logic               irq_o;

    logic [31:0] lcg_state;
    int          n_checks;
    int          n_errors;
    bit          timed_out;   // later commands are skipped once set

    trap_unit_top #(
        .TICK_DIV (1)
    ) u_dut (
        .clk   (clk),
        .rst   (rst),
        .req_i (req_i),
        .cmd_i (cmd_i),
        .ack_o (ack_o),
        .rsp_o (rsp_o),
        .irq_o (irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic trap_pkg::xlen_t rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi, lo};
    endfunction

    task automatic check_val(input string name, input trap_pkg::xlen_t exp,
                             input trap_pkg::xlen_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic note_timeout(input string what);
        timed_out = 1'b1;
        n_errors++;
        $display("Timeout at %0t ns: %s", $time, what);
    endtask

    // one full four-phase cycle; hold keeps req_i high for extra cycles
    task automatic do_cmd(input trap_pkg::csr_op_t op, input trap_pkg::csr_idx_t idx,
                          input trap_pkg::xlen_t wdata, input trap_pkg::xlen_t pc,
                          input int hold, output trap_pkg::csr_rsp_t rsp);
        int waited;
        rsp = '0;
        if (timed_out) return;
        @(negedge clk);
        check_val("ack_o before req_i", 64'd0, 64'(ack_o));
        cmd_i.op    = op;
        cmd_i.idx   = idx;
        cmd_i.wdata = wdata;
        cmd_i.pc    = pc;
        req_i       = 1'b1;
        waited      = 0;
        while (!ack_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!ack_o) begin
            req_i = 1'b0;
            note_timeout("ack_o never rose after req_i");
            return;
        end
        check_val("ack_o latency", 64'd2, 64'(waited));   // latch edge, then execute edge
        rsp = rsp_o;
        repeat (hold) begin
            @(negedge clk);
            check_val("ack_o held", 64'd1, 64'(ack_o));
            check_val("rsp_o.rdata held", rsp.rdata, rsp_o.rdata);
            check_val("rsp_o.redirect held", 64'(rsp.redirect), 64'(rsp_o.redirect));
            check_val("rsp_o.target held", rsp.target, rsp_o.target);
        end
        req_i  = 1'b0;
        waited = 0;
        while (ack_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (ack_o) begin
            note_timeout("ack_o stayed high after req_i fell");
        end
    endtask

    task automatic expect_rdata(input trap_pkg::csr_op_t op, input trap_pkg::csr_idx_t idx,
                                input trap_pkg::xlen_t wdata, input trap_pkg::xlen_t exp,
                                input string name);
        trap_pkg::csr_rsp_t rsp;
        do_cmd(op, idx, wdata, 64'd0, 0, rsp);
        check_val(name, exp, rsp.rdata);
        check_val({name, " redirect"}, 64'd0, 64'(rsp.redirect));   // csr ops never redirect
    endtask

    task automatic read_csr(input trap_pkg::csr_idx_t idx, output trap_pkg::xlen_t val);
        trap_pkg::csr_rsp_t rsp;
        do_cmd(trap_pkg::OP_READ, idx, 64'd0, 64'd0, 0, rsp);
        val = rsp.rdata;
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (n_errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, n_errors - errs_before);
        end
    endtask

    task automatic test_reset_state();
        int              errs;
        trap_pkg::xlen_t val;
        errs = n_errors;
        for (int i = 0; i < 8; i++) begin
            read_csr(trap_pkg::csr_idx_t'(i), val);
            if (i == 6) begin   // mtime has been counting since reset
                check_val("mtime small nonzero", 64'd1, 64'(val != 64'd0 && val < 64'd1000));
            end else if (i == 7) begin
                check_val("mtimecmp", 64'hFFFF_FFFF_FFFF_FFFF, val);
            end else begin
                check_val($sformatf("csr[%0d]", i), 64'd0, val);
            end
        end
        check_val("irq_o", 64'd0, 64'(irq_o));
        report_test("reset_state", errs);
    endtask

    // rw, rs, rc and read against a local model of the register
    task automatic exercise_csr(input trap_pkg::csr_idx_t idx, input string name,
                                input trap_pkg::xlen_t mask);
        trap_pkg::xlen_t cur;
        trap_pkg::xlen_t wd;
        read_csr(idx, cur);
        wd = rand64();
        expect_rdata(trap_pkg::OP_RW, idx, wd, cur, {name, " rw old"});
        cur = wd & mask;
        wd  = rand64();
        expect_rdata(trap_pkg::OP_RS, idx, wd, cur, {name, " rs old"});
        cur = (cur | wd) & mask;
        wd  = rand64();
        expect_rdata(trap_pkg::OP_RC, idx, wd, cur, {name, " rc old"});
        cur = cur & ~wd;
        expect_rdata(trap_pkg::OP_RS, idx, 64'd0, cur, {name, " rs zero old"});
        expect_rdata(trap_pkg::OP_READ, idx, wd, cur, {name, " read"});   // read never writes
        expect_rdata(trap_pkg::OP_READ, idx, 64'd0, cur, {name, " final"});
    endtask

    task automatic test_csr_ops();
        int                 errs;
        trap_pkg::xlen_t    val;
        trap_pkg::xlen_t    t0;
        trap_pkg::csr_rsp_t rsp;
        errs = n_errors;
        exercise_csr(trap_pkg::CSR_MEPC, "mepc", 64'hFFFF_FFFF_FFFF_FFFF);
        exercise_csr(trap_pkg::CSR_MTVEC, "mtvec", ~64'd3);
        read_csr(trap_pkg::CSR_MTVEC, val);
        check_val("mtvec[1:0]", 64'd0, val & 64'd3);
        // read-only registers
        expect_rdata(trap_pkg::OP_RW, trap_pkg::CSR_MIP, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0,
                     "mip rw old");
        read_csr(trap_pkg::CSR_MIP, val);
        check_val("mip", 64'd0, val);
        read_csr(trap_pkg::CSR_MTIME, t0);
        do_cmd(trap_pkg::OP_RW, trap_pkg::CSR_MTIME, 64'd0, 64'd0, 0, rsp);
        check_val("mtime advanced", 64'd1, 64'(rsp.rdata > t0));
        read_csr(trap_pkg::CSR_MTIME, val);
        check_val("mtime not cleared", 64'd1, 64'(val > rsp.rdata));
        report_test("csr_ops", errs);
    endtask

    task automatic test_ecall_mret();
        int                 errs;
        trap_pkg::xlen_t    val;
        trap_pkg::csr_rsp_t rsp;
        errs = n_errors;
        do_cmd(trap_pkg::OP_RW, trap_pkg::CSR_MTVEC, VEC, 64'd0, 0, rsp);
        do_cmd(trap_pkg::OP_RW, trap_pkg::CSR_MSTATUS, 64'h8, 64'd0, 0, rsp);   // MIE only
        do_cmd(trap_pkg::OP_ECALL, trap_pkg::CSR_MSTATUS, 64'd0, ECALL_PC, 0, rsp);
        check_val("ecall redirect", 64'd1, 64'(rsp.redirect));
        check_val("ecall target", VEC, rsp.target);
        check_val("ecall rdata", 64'd0, rsp.rdata);
        read_csr(trap_pkg::CSR_MEPC, val);
        check_val("mepc", ECALL_PC, val);
        read_csr(trap_pkg::CSR_MCAUSE, val);
        check_val("mcause", 64'd11, val);
        read_csr(trap_pkg::CSR_MSTATUS, val);
        check_val("mstatus after ecall", 64'h80, val);   // MPIE 1, MIE 0
        do_cmd(trap_pkg::OP_MRET, trap_pkg::CSR_MSTATUS, 64'd0, 64'd0, 0, rsp);
        check_val("mret redirect", 64'd1, 64'(rsp.redirect));
        check_val("mret target", ECALL_PC, rsp.target);
        read_csr(trap_pkg::CSR_MSTATUS, val);
        check_val("mstatus after mret", 64'h88, val);
        report_test("ecall_mret", errs);
    endtask

    task automatic test_timer_irq();
        int                 errs;
        int                 waited;
        trap_pkg::xlen_t    val;
        trap_pkg::xlen_t    cmp;
        trap_pkg::csr_rsp_t rsp;
        errs = n_errors;
        do_cmd(trap_pkg::OP_RW, trap_pkg::CSR_MSTATUS, 64'h8, 64'd0, 0, rsp);
        do_cmd(trap_pkg::OP_RW, trap_pkg::CSR_MIE, 64'h80, 64'd0, 0, rsp);     // MTIE
        read_csr(trap_pkg::CSR_MTIME, val);
        cmp = val + 64'd40;
        do_cmd(trap_pkg::OP_RW, trap_pkg::CSR_MTIMECMP, cmp, 64'd0, 0, rsp);
        check_val("irq_o before compare", 64'd0, 64'(irq_o));
        waited = 0;
        while (!irq_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!irq_o) begin
            note_timeout("irq_o never rose after mtime reached mtimecmp");
        end
        read_csr(trap_pkg::CSR_MTIME, val);
        check_val("mtime at irq", 64'd1, 64'(val >= cmp));
        do_cmd(trap_pkg::OP_IRQ, trap_pkg::CSR_MSTATUS, 64'd0, IRQ_PC, 0, rsp);
        check_val("irq redirect", 64'd1, 64'(rsp.redirect));
        check_val("irq target", VEC, rsp.target);
        check_val("irq_o after entry", 64'd0, 64'(irq_o));
        read_csr(trap_pkg::CSR_MCAUSE, val);
        check_val("mcause", 64'h8000_0000_0000_0007, val);
        read_csr(trap_pkg::CSR_MEPC, val);
        check_val("mepc", IRQ_PC, val);
        do_cmd(trap_pkg::OP_MRET, trap_pkg::CSR_MSTATUS, 64'd0, 64'd0, 0, rsp);
        check_val("mret target", IRQ_PC, rsp.target);
        do_cmd(trap_pkg::OP_RW, trap_pkg::CSR_MTIMECMP, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0, 0, rsp);
        repeat (10) begin
            @(negedge clk);
            check_val("irq_o after rearm", 64'd0, 64'(irq_o));
        end
        report_test("timer_irq", errs);
    endtask

    task automatic test_handshake();
        int                 errs;
        trap_pkg::xlen_t    v;
        trap_pkg::xlen_t    prev;
        trap_pkg::csr_rsp_t rsp;
        errs = n_errors;
        read_csr(trap_pkg::CSR_MEPC, prev);
        v = rand64();
        do_cmd(trap_pkg::OP_RW, trap_pkg::CSR_MEPC, v, 64'd0, 5, rsp);   // long hold
        check_val("long hold rdata", prev, rsp.rdata);
        prev = v;
        for (int i = 0; i < 6; i++) begin
            v = rand64();
            do_cmd(trap_pkg::OP_RW, trap_pkg::CSR_MEPC, v, 64'd0, int'(lcg_next() % 32'd4), rsp);
            check_val("back-to-back rdata", prev, rsp.rdata);
            prev = v;
        end
        report_test("handshake", errs);
    endtask

    initial begin
        rst       = 1'b1;
        req_i     = 1'b0;
        cmd_i     = '0;
        lcg_state = 32'd43;
        n_checks  = 0;
        n_errors  = 0;
        timed_out = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_csr_ops();
        test_ecall_mret();
        test_timer_irq();
        test_handshake();
        $display("checks: %0d run, %0d failed", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/trap_pkg.sv
hw/csr_cmd_port.sv
hw/trap_ctrl.sv
hw/mcsr_file.sv
hw/mtimer.sv
hw/trap_unit_top.sv
sim/trap_unit_assertions.sv
sim/trap_unit_tb.sv
